// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_daq_core
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := ERRORS FOUND
PASS_MSG   := NO ERRORS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/daq_bus_decoder.sv
`timescale 1ns/1ps
`include "daq_params.svh"

module daq_bus_decoder (
    input  logic                       BUS_CLK,
    input  logic                       BUS_RST,
    input  logic [`DAQ_ABUS_WIDTH-1:0] i_bus_add,
    input  logic [`DAQ_DBUS_WIDTH-1:0] i_bus_data,
    input  logic                       i_bus_rd,
    input  logic                       i_bus_wr,
    output logic [`DAQ_DBUS_WIDTH-1:0] o_bus_data,
    daq_bus_if.decoder                 sys_bus,
    daq_bus_if.decoder                 pulse_bus
);

    logic                       sys_hit;
    logic                       pulse_hit;
    logic [`DAQ_ABUS_WIDTH-1:0] sys_off;
    logic [`DAQ_ABUS_WIDTH-1:0] pulse_off;
    logic                       rd_sys_q;
    logic                       rd_pulse_q;

    assign sys_hit   = (i_bus_add >= `DAQ_SYS_BASEADDR) && (i_bus_add <= `DAQ_SYS_HIGHADDR);
    assign pulse_hit = (i_bus_add >= `DAQ_PULSE_BASEADDR) && (i_bus_add <= `DAQ_PULSE_HIGHADDR);

    // Offset relative to each block base
    assign sys_off   = i_bus_add - `DAQ_SYS_BASEADDR;
    assign pulse_off = i_bus_add - `DAQ_PULSE_BASEADDR;

    assign sys_bus.rd    = i_bus_rd & sys_hit;
    assign sys_bus.wr    = i_bus_wr & sys_hit;
    assign sys_bus.add   = sys_off[`DAQ_BLK_ADD_WIDTH-1:0];
    assign sys_bus.wdata = i_bus_data;

    assign pulse_bus.rd    = i_bus_rd & pulse_hit;
    assign pulse_bus.wr    = i_bus_wr & pulse_hit;
    assign pulse_bus.add   = pulse_off[`DAQ_BLK_ADD_WIDTH-1:0];
    assign pulse_bus.wdata = i_bus_data;

    // Remember which block answers the pending read
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rd_sys_q   <= 1'b0;
            rd_pulse_q <= 1'b0;
        end else begin
            rd_sys_q   <= sys_bus.rd;
            rd_pulse_q <= pulse_bus.rd;
        end
    end

    // Unmapped or idle cycles read as zero
    assign o_bus_data = rd_sys_q   ? sys_bus.rdata :
                        rd_pulse_q ? pulse_bus.rdata : '0;

    a_one_block: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !((sys_bus.rd || sys_bus.wr) && (pulse_bus.rd || pulse_bus.wr)));

endmodule

// File: design/daq_bus_if.sv
`timescale 1ns/1ps
`include "daq_params.svh"

interface daq_bus_if;

    // Strobes are already gated by the block's address range
    logic                          rd;
    logic                          wr;
    logic [`DAQ_BLK_ADD_WIDTH-1:0] add;
    logic [`DAQ_DBUS_WIDTH-1:0]    wdata;
    logic [`DAQ_DBUS_WIDTH-1:0]    rdata;

    modport decoder (
        output rd,
        output wr,
        output add,
        output wdata,
        input  rdata
    );

    modport block (
        input  rd,
        input  wr,
        input  add,
        input  wdata,
        output rdata
    );

endinterface

// File: design/daq_core.sv
`timescale 1ns/1ps
`include "daq_params.svh"

module daq_core (
    input  logic                       BUS_CLK,
    input  logic                       BUS_RST,
    input  logic [`DAQ_ABUS_WIDTH-1:0] i_bus_add,
    input  logic [`DAQ_DBUS_WIDTH-1:0] i_bus_data,
    input  logic                       i_bus_rd,
    input  logic                       i_bus_wr,
    output logic [`DAQ_DBUS_WIDTH-1:0] o_bus_data,

    input  logic [3:0]                 i_gpio_sense,
    input  logic                       i_ext_start,
    output logic                       o_mgt_ref_sel,
    output logic [7:0]                 o_lemo_mux,
    output logic [2:0]                 o_ntc_mux,
    output logic                       o_resetb_ext,

    input  logic                       i_rx_fifo_empty,
    input  logic [`DAQ_WORD_WIDTH-1:0] i_rx_fifo_data,
    output logic                       o_rx_fifo_read,
    input  logic                       i_tlu_fifo_empty,
    input  logic [`DAQ_WORD_WIDTH-1:0] i_tlu_fifo_data,
    input  logic                       i_tlu_fifo_preempt_req,
    output logic                       o_tlu_fifo_read,
    input  logic                       i_tdc_fifo_empty,
    input  logic [`DAQ_WORD_WIDTH-1:0] i_tdc_fifo_data,
    output logic                       o_tdc_fifo_read,

    input  logic                       i_arb_ready,
    output logic                       o_arb_write,
    output logic [`DAQ_WORD_WIDTH-1:0] o_arb_data
);

    logic rst_pulse;

    daq_bus_if sys_bus ();
    daq_bus_if pulse_bus ();

    daq_bus_decoder i_bus_decoder (
        .BUS_CLK    (BUS_CLK),
        .BUS_RST    (BUS_RST),
        .i_bus_add  (i_bus_add),
        .i_bus_data (i_bus_data),
        .i_bus_rd   (i_bus_rd),
        .i_bus_wr   (i_bus_wr),
        .o_bus_data (o_bus_data),
        .sys_bus    (sys_bus.decoder),
        .pulse_bus  (pulse_bus.decoder)
    );

    daq_system_regs i_system_regs (
        .BUS_CLK       (BUS_CLK),
        .BUS_RST       (BUS_RST),
        .bus           (sys_bus.block),
        .i_gpio_sense  (i_gpio_sense),
        .i_rst_pulse   (rst_pulse),
        .o_mgt_ref_sel (o_mgt_ref_sel),
        .o_lemo_mux    (o_lemo_mux),
        .o_ntc_mux     (o_ntc_mux),
        .o_resetb_ext  (o_resetb_ext)
    );

    daq_pulse_gen i_pulse_gen_rst (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .bus         (pulse_bus.block),
        .i_ext_start (i_ext_start),
        .o_pulse     (rst_pulse)
    );

    // Index 2 is rx, 1 is tlu, 0 is tdc; only the trigger unit can hold
    daq_rr_arbiter i_rr_arbiter (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .i_src_empty ({i_rx_fifo_empty, i_tlu_fifo_empty, i_tdc_fifo_empty}),
        .i_src_data  ({i_rx_fifo_data, i_tlu_fifo_data, i_tdc_fifo_data}),
        .i_src_hold  ({1'b0, i_tlu_fifo_preempt_req, 1'b0}),
        .o_src_read  ({o_rx_fifo_read, o_tlu_fifo_read, o_tdc_fifo_read}),
        .i_arb_ready (i_arb_ready),
        .o_arb_write (o_arb_write),
        .o_arb_data  (o_arb_data)
    );

endmodule

// File: design/daq_pkg.sv
package daq_pkg;

    typedef enum logic [1:0] {
        ARB_IDLE  = 2'd0,
        ARB_ROUND = 2'd1,
        ARB_HOLD  = 2'd2
    } arb_state_e;

    // System block offsets
    typedef enum logic [7:0] {
        SYS_VERSION    = 8'd0,
        SYS_VER_MINOR  = 8'd1,
        SYS_VER_MAJOR  = 8'd2,
        SYS_BOARD      = 8'd3,
        SYS_CLK_CFG_RD = 8'd4,
        SYS_CLK_CFG_WR = 8'd5,
        SYS_LEMO_MUX   = 8'd6,
        SYS_CONTROL    = 8'd7,
        SYS_SENSE      = 8'd8
    } sys_reg_e;

    // Reset pulser offsets
    typedef enum logic [7:0] {
        PULSE_START  = 8'd0,
        PULSE_EXT_EN = 8'd1,
        PULSE_DELAY  = 8'd2,
        PULSE_WIDTH  = 8'd3,
        PULSE_DONE   = 8'd4
    } pulse_reg_e;

endpackage

// File: design/daq_pulse_gen.sv
`timescale 1ns/1ps
`include "daq_params.svh"

module daq_pulse_gen (
    input  logic     BUS_CLK,
    input  logic     BUS_RST,
    daq_bus_if.block bus,
    input  logic     i_ext_start,
    output logic     o_pulse
);

    logic       ext_en_q;
    logic [7:0] delay_q;
    logic [7:0] width_q;
    logic [7:0] cnt_q;
    logic       busy_q;
    logic       start;

    assign start = (bus.wr && bus.add == daq_pkg::PULSE_START) || (ext_en_q && i_ext_start);

    // Busy with o_pulse low is the delay phase, busy with o_pulse high the width phase
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ext_en_q <= 1'b0;
            delay_q  <= 8'd0;
            width_q  <= 8'd0;
            cnt_q    <= 8'd0;
            busy_q   <= 1'b0;
            o_pulse  <= 1'b0;
        end else begin
            if (bus.wr) begin
                case (bus.add)
                    daq_pkg::PULSE_EXT_EN: ext_en_q <= bus.wdata[0];
                    daq_pkg::PULSE_DELAY:  delay_q  <= bus.wdata;
                    daq_pkg::PULSE_WIDTH:  width_q  <= bus.wdata;
                    default: ;
                endcase
            end

            if (!busy_q) begin
                // Starts while busy are dropped
                if (start) begin
                    busy_q <= 1'b1;
                    cnt_q  <= delay_q;
                end
            end else if (!o_pulse) begin
                if (cnt_q == 8'd0) begin
                    if (width_q == 8'd0) begin
                        busy_q <= 1'b0;
                    end else begin
                        o_pulse <= 1'b1;
                        cnt_q   <= width_q - 8'd1;
                    end
                end else begin
                    cnt_q <= cnt_q - 8'd1;
                end
            end else begin
                if (cnt_q == 8'd0) begin
                    o_pulse <= 1'b0;
                    busy_q  <= 1'b0;
                end else begin
                    cnt_q <= cnt_q - 8'd1;
                end
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (bus.rd) begin
            case (bus.add)
                daq_pkg::PULSE_EXT_EN: bus.rdata <= {7'd0, ext_en_q};
                daq_pkg::PULSE_DELAY:  bus.rdata <= delay_q;
                daq_pkg::PULSE_WIDTH:  bus.rdata <= width_q;
                daq_pkg::PULSE_DONE:   bus.rdata <= {7'd0, ~busy_q};
                default:               bus.rdata <= 8'd0;
            endcase
        end
    end

    // Width as seen when the delay phase ended
    a_no_zero_width: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        $rose(o_pulse) |-> $past(width_q) != 8'd0);

endmodule

// File: design/daq_rr_arbiter.sv
`timescale 1ns/1ps
`include "daq_params.svh"

module daq_rr_arbiter (
    input  logic                                           BUS_CLK,
    input  logic                                           BUS_RST,
    input  logic [`DAQ_N_SOURCES-1:0]                      i_src_empty,
    input  logic [`DAQ_N_SOURCES-1:0][`DAQ_WORD_WIDTH-1:0] i_src_data,
    input  logic [`DAQ_N_SOURCES-1:0]                      i_src_hold,
    output logic [`DAQ_N_SOURCES-1:0]                      o_src_read,
    input  logic                                           i_arb_ready,
    output logic                                           o_arb_write,
    output logic [`DAQ_WORD_WIDTH-1:0]                     o_arb_data
);

    daq_pkg::arb_state_e             state_q;
    daq_pkg::arb_state_e             state_d;
    logic [1:0]                      last_q;
    logic [1:0]                      rr_idx;
    logic                            rr_found;
    logic [1:0]                      sel_idx;
    logic                            hold_ok;
    logic [`DAQ_N_SOURCES-1:0]       req;

    assign req = ~i_src_empty;

    // First requester after the last grant, in descending index order
    always_comb begin
        int cand;
        rr_found = 1'b0;
        rr_idx   = last_q;
        for (int k = 1; k <= `DAQ_N_SOURCES; k++) begin
            cand = (int'(last_q) + `DAQ_N_SOURCES - k) % `DAQ_N_SOURCES;
            if (!rr_found && req[cand]) begin
                rr_found = 1'b1;
                rr_idx   = 2'(cand);
            end
        end
    end

    // Locked source keeps the grant while it holds and has data
    assign hold_ok = (state_q == daq_pkg::ARB_HOLD) && req[last_q] && i_src_hold[last_q];
    assign sel_idx = hold_ok ? last_q : rr_idx;

    always_comb begin
        o_src_read = '0;
        if (i_arb_ready && rr_found) begin
            o_src_read[sel_idx] = 1'b1;
        end

        if (o_src_read != '0) begin
            state_d = i_src_hold[sel_idx] ? daq_pkg::ARB_HOLD : daq_pkg::ARB_ROUND;
        end else if (hold_ok) begin
            state_d = daq_pkg::ARB_HOLD;
        end else if (rr_found) begin
            state_d = daq_pkg::ARB_ROUND;
        end else begin
            state_d = daq_pkg::ARB_IDLE;
        end
    end

    // Pointer starts on tdc so rx wins the first round
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            state_q     <= daq_pkg::ARB_IDLE;
            last_q      <= 2'd0;
            o_arb_write <= 1'b0;
        end else begin
            state_q     <= state_d;
            o_arb_write <= |o_src_read;
            if (o_src_read != '0) begin
                last_q <= sel_idx;
            end
        end
    end

    // Head word is popped and captured on the same edge
    always_ff @(posedge BUS_CLK) begin
        if (o_src_read != '0) begin
            o_arb_data <= i_src_data[sel_idx];
        end
    end

    a_read_onehot: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        $onehot0(o_src_read));

    a_no_read_stalled: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !i_arb_ready |-> o_src_read == '0);

    a_no_read_empty: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        (o_src_read & i_src_empty) == '0);

endmodule

// File: design/daq_system_regs.sv
`timescale 1ns/1ps
`include "daq_params.svh"

module daq_system_regs (
    input  logic       BUS_CLK,
    input  logic       BUS_RST,
    daq_bus_if.block   bus,
    input  logic [3:0] i_gpio_sense,
    input  logic       i_rst_pulse,
    output logic       o_mgt_ref_sel,
    output logic [7:0] o_lemo_mux,
    output logic [2:0] o_ntc_mux,
    output logic       o_resetb_ext
);

    logic       clk_cfg_q;
    logic [7:0] lemo_q;
    logic [7:0] ctrl_q;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            clk_cfg_q <= 1'b0;
            lemo_q    <= 8'd0;
            ctrl_q    <= 8'd0;
        end else if (bus.wr) begin
            case (bus.add)
                daq_pkg::SYS_CLK_CFG_WR: clk_cfg_q <= bus.wdata[0];
                daq_pkg::SYS_LEMO_MUX:   lemo_q    <= bus.wdata;
                daq_pkg::SYS_CONTROL:    ctrl_q    <= bus.wdata;
                default: ;
            endcase
        end
    end

    // Readback captured on the read strobe
    always_ff @(posedge BUS_CLK) begin
        if (bus.rd) begin
            case (bus.add)
                daq_pkg::SYS_VERSION:    bus.rdata <= `DAQ_MODULE_VERSION;
                daq_pkg::SYS_VER_MINOR:  bus.rdata <= `DAQ_VERSION_MINOR;
                daq_pkg::SYS_VER_MAJOR:  bus.rdata <= `DAQ_VERSION_MAJOR;
                daq_pkg::SYS_BOARD:      bus.rdata <= `DAQ_BOARD_ID;
                daq_pkg::SYS_CLK_CFG_RD: bus.rdata <= {7'd0, clk_cfg_q};
                daq_pkg::SYS_LEMO_MUX:   bus.rdata <= lemo_q;
                daq_pkg::SYS_CONTROL:    bus.rdata <= ctrl_q;
                daq_pkg::SYS_SENSE:      bus.rdata <= {4'd0, i_gpio_sense};
                default:                 bus.rdata <= 8'd0;
            endcase
        end
    end

    // Control bit 0 set means external reference, so zero keeps the internal clock
    assign o_mgt_ref_sel = ~ctrl_q[0];
    assign o_ntc_mux     = ctrl_q[3:1];
    assign o_lemo_mux    = lemo_q;

    // Chip held in reset by software or by the reset pulser
    assign o_resetb_ext = ~(ctrl_q[4] | i_rst_pulse);

endmodule

// File: filelist.f
+incdir+include
design/daq_pkg.sv
design/daq_bus_if.sv
design/daq_bus_decoder.sv
design/daq_system_regs.sv
design/daq_pulse_gen.sv
design/daq_rr_arbiter.sv
design/daq_core.sv
verification/tb_daq_core.sv

// File: include/daq_params.svh
`ifndef DAQ_PARAMS_SVH
`define DAQ_PARAMS_SVH

// Local bus widths
`define DAQ_ABUS_WIDTH 32
`define DAQ_DBUS_WIDTH 8

// Offset width inside one register block
`define DAQ_BLK_ADD_WIDTH 8

// Absolute address map
`define DAQ_SYS_BASEADDR   32'h0000_0300
`define DAQ_SYS_HIGHADDR   32'h0000_03FF
`define DAQ_PULSE_BASEADDR 32'h0000_0400
`define DAQ_PULSE_HIGHADDR 32'h0000_04FF

// Version and board readback
`define DAQ_MODULE_VERSION 8'd1
`define DAQ_VERSION_MINOR  8'd2
`define DAQ_VERSION_MAJOR  8'd0
// 0 is the simulation board
`define DAQ_BOARD_ID       8'd0

// Source FIFOs and output stream
`define DAQ_WORD_WIDTH 32
`define DAQ_N_SOURCES  3

`endif

// File: verification/tb_daq_core.sv
`timescale 1ns/1ps
`include "daq_params.svh"

module tb_daq_core;

    localparam int CLK_PERIOD   = 40;
    localparam int SEED         = 98;
    // Cycle budget of each test
    localparam int BUDGET_REGS  = 100;
    localparam int BUDGET_CTRL  = 100;
    localparam int BUDGET_PULSE = 400;
    localparam int BUDGET_EXT   = 300;
    localparam int BUDGET_RR    = 300;
    localparam int BUDGET_HOLD  = 300;
    localparam int TIMEOUT_CYCLES = BUDGET_REGS + BUDGET_CTRL + BUDGET_PULSE + BUDGET_EXT
                                  + BUDGET_RR + BUDGET_HOLD;

    logic                       BUS_CLK = 1'b0;
    logic                       BUS_RST = 1'b1;
    logic [`DAQ_ABUS_WIDTH-1:0] i_bus_add = '0;
    logic [`DAQ_DBUS_WIDTH-1:0] i_bus_data = '0;
    logic                       i_bus_rd = 1'b0;
    logic                       i_bus_wr = 1'b0;
    logic [`DAQ_DBUS_WIDTH-1:0] o_bus_data;
    logic [3:0]                 i_gpio_sense = 4'd0;
    logic                       i_ext_start = 1'b0;
    logic                       o_mgt_ref_sel;
    logic [7:0]                 o_lemo_mux;
    logic [2:0]                 o_ntc_mux;
    logic                       o_resetb_ext;
    logic                       i_rx_fifo_empty = 1'b1;
    logic [`DAQ_WORD_WIDTH-1:0] i_rx_fifo_data = '0;
    logic                       o_rx_fifo_read;
    logic                       i_tlu_fifo_empty = 1'b1;
    logic [`DAQ_WORD_WIDTH-1:0] i_tlu_fifo_data = '0;
    logic                       i_tlu_fifo_preempt_req = 1'b0;
    logic                       o_tlu_fifo_read;
    logic                       i_tdc_fifo_empty = 1'b1;
    logic [`DAQ_WORD_WIDTH-1:0] i_tdc_fifo_data = '0;
    logic                       o_tdc_fifo_read;
    logic                       i_arb_ready = 1'b1;
    logic                       o_arb_write;
    logic [`DAQ_WORD_WIDTH-1:0] o_arb_data;

    // Source FIFO contents, arbiter output log and expected stream
    logic [`DAQ_WORD_WIDTH-1:0] rx_q[$];
    logic [`DAQ_WORD_WIDTH-1:0] tlu_q[$];
    logic [`DAQ_WORD_WIDTH-1:0] tdc_q[$];
    logic [`DAQ_WORD_WIDTH-1:0] out_q[$];
    logic [`DAQ_WORD_WIDTH-1:0] exp_q[$];
    int errors = 0;
    int checks = 0;

    daq_core i_dut (
        .BUS_CLK                (BUS_CLK),
        .BUS_RST                (BUS_RST),
        .i_bus_add              (i_bus_add),
        .i_bus_data             (i_bus_data),
        .i_bus_rd               (i_bus_rd),
        .i_bus_wr               (i_bus_wr),
        .o_bus_data             (o_bus_data),
        .i_gpio_sense           (i_gpio_sense),
        .i_ext_start            (i_ext_start),
        .o_mgt_ref_sel          (o_mgt_ref_sel),
        .o_lemo_mux             (o_lemo_mux),
        .o_ntc_mux              (o_ntc_mux),
        .o_resetb_ext           (o_resetb_ext),
        .i_rx_fifo_empty        (i_rx_fifo_empty),
        .i_rx_fifo_data         (i_rx_fifo_data),
        .o_rx_fifo_read         (o_rx_fifo_read),
        .i_tlu_fifo_empty       (i_tlu_fifo_empty),
        .i_tlu_fifo_data        (i_tlu_fifo_data),
        .i_tlu_fifo_preempt_req (i_tlu_fifo_preempt_req),
        .o_tlu_fifo_read        (o_tlu_fifo_read),
        .i_tdc_fifo_empty       (i_tdc_fifo_empty),
        .i_tdc_fifo_data        (i_tdc_fifo_data),
        .o_tdc_fifo_read        (o_tdc_fifo_read),
        .i_arb_ready            (i_arb_ready),
        .o_arb_write            (o_arb_write),
        .o_arb_data             (o_arb_data)
    );

    always #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;

    task automatic note_error(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    // Head word leaves the FIFO on the edge where the DUT captures it
    always @(posedge BUS_CLK) begin
        if (o_rx_fifo_read) begin
            if (rx_q.size() != 0) void'(rx_q.pop_front());
            else note_error("rx FIFO read while empty");
        end
        if (o_tlu_fifo_read) begin
            if (tlu_q.size() != 0) void'(tlu_q.pop_front());
            else note_error("tlu FIFO read while empty");
        end
        if (o_tdc_fifo_read) begin
            if (tdc_q.size() != 0) void'(tdc_q.pop_front());
            else note_error("tdc FIFO read while empty");
        end
    end

    // FIFO flags and head words, plus the output word log
    always @(negedge BUS_CLK) begin
        i_rx_fifo_empty  = (rx_q.size() == 0);
        i_rx_fifo_data   = (rx_q.size() != 0) ? rx_q[0] : '0;
        i_tlu_fifo_empty = (tlu_q.size() == 0);
        i_tlu_fifo_data  = (tlu_q.size() != 0) ? tlu_q[0] : '0;
        i_tdc_fifo_empty = (tdc_q.size() == 0);
        i_tdc_fifo_data  = (tdc_q.size() != 0) ? tdc_q[0] : '0;
        if (o_arb_write) out_q.push_back(o_arb_data);
    end

    task automatic check_byte(input string name, input logic [`DAQ_DBUS_WIDTH-1:0] exp,
                              input logic [`DAQ_DBUS_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [`DAQ_WORD_WIDTH-1:0] exp,
                              input logic [`DAQ_WORD_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    function automatic logic [`DAQ_ABUS_WIDTH-1:0] sys_addr(input daq_pkg::sys_reg_e r);
        return `DAQ_SYS_BASEADDR + 32'(r);
    endfunction

    function automatic logic [`DAQ_ABUS_WIDTH-1:0] pulse_addr(input daq_pkg::pulse_reg_e r);
        return `DAQ_PULSE_BASEADDR + 32'(r);
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    // Source tag in the top nibble
    function automatic logic [`DAQ_WORD_WIDTH-1:0] tagged_word(input logic [3:0] tag);
        logic [31:0] r;
        r = $urandom();
        return {tag, r[27:0]};
    endfunction

    task automatic bus_write(input logic [`DAQ_ABUS_WIDTH-1:0] addr,
                             input logic [`DAQ_DBUS_WIDTH-1:0] data);
        @(negedge BUS_CLK);
        i_bus_add  = addr;
        i_bus_data = data;
        i_bus_wr   = 1'b1;
        @(negedge BUS_CLK);
        i_bus_wr   = 1'b0;
    endtask

    // Read data is valid in the cycle after the strobe edge
    task automatic bus_read(input logic [`DAQ_ABUS_WIDTH-1:0] addr,
                            output logic [`DAQ_DBUS_WIDTH-1:0] data);
        @(negedge BUS_CLK);
        i_bus_add = addr;
        i_bus_rd  = 1'b1;
        @(negedge BUS_CLK);
        data      = o_bus_data;
        i_bus_rd  = 1'b0;
    endtask

    task automatic ext_start_pulse();
        @(negedge BUS_CLK);
        i_ext_start = 1'b1;
        @(negedge BUS_CLK);
        i_ext_start = 1'b0;
    endtask

    // Called one half cycle after the start edge; low from delay+1 for width cycles
    task automatic check_pulse_shape(input string name, input int delay, input int width);
        for (int k = 1; k <= delay + width + 2; k++) begin
            @(negedge BUS_CLK);
            check_bit(name, !(k >= delay + 1 && k < delay + 1 + width), o_resetb_ext);
        end
    endtask

    task automatic wait_pulse_idle(input string name);
        logic [7:0] d;
        int n;
        d = 8'd0;
        n = 0;
        while (d[0] !== 1'b1 && n < 100) begin
            bus_read(pulse_addr(daq_pkg::PULSE_DONE), d);
            n++;
        end
        if (d[0] !== 1'b1) note_error({name, ": pulse generator never reported done"});
    endtask

    task automatic wait_words(input string name, input int count);
        int n;
        n = 0;
        while (out_q.size() < count && n < BUDGET_RR) begin
            @(negedge BUS_CLK);
            n++;
        end
        // A few more cycles to catch surplus words
        repeat (4) @(negedge BUS_CLK);
        if (out_q.size() != count) begin
            note_error($sformatf("%s: arbiter wrote %0d words, expected %0d",
                                 name, out_q.size(), count));
        end
    endtask

    task automatic compare_stream(input string name);
        for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
            check_word(name, exp_q[i], out_q[i]);
        end
    endtask

    task automatic test_reg_readback();
        logic [7:0] d;
        bus_read(sys_addr(daq_pkg::SYS_VERSION), d);
        check_byte("reg_readback", `DAQ_MODULE_VERSION, d);
        bus_read(sys_addr(daq_pkg::SYS_VER_MINOR), d);
        check_byte("reg_readback", `DAQ_VERSION_MINOR, d);
        bus_read(sys_addr(daq_pkg::SYS_VER_MAJOR), d);
        check_byte("reg_readback", `DAQ_VERSION_MAJOR, d);
        bus_read(sys_addr(daq_pkg::SYS_BOARD), d);
        check_byte("reg_readback", `DAQ_BOARD_ID, d);
        bus_read(sys_addr(daq_pkg::SYS_CLK_CFG_RD), d);
        check_byte("reg_readback", 8'd0, d);
        check_bit("reg_readback", 1'b1, o_mgt_ref_sel);
        check_bit("reg_readback", 1'b1, o_resetb_ext);
        check_byte("reg_readback", 8'd0, o_lemo_mux);
        check_byte("reg_readback", 8'd0, {5'd0, o_ntc_mux});
        bus_write(sys_addr(daq_pkg::SYS_CLK_CFG_WR), 8'd1);
        bus_read(sys_addr(daq_pkg::SYS_CLK_CFG_RD), d);
        check_byte("reg_readback", 8'd1, d);
        // Below and above both ranges, at offsets that would read 1 in either block
        bus_read(32'h0000_0204, d);
        check_byte("reg_readback", 8'd0, d);
        bus_read(32'h0000_0504, d);
        check_byte("reg_readback", 8'd0, d);
    endtask

    task automatic test_control_outputs();
        logic [7:0] lemo;
        logic [7:0] ctrl;
        logic [7:0] r;
        logic [7:0] d;
        lemo = rand_byte();
        ctrl = rand_byte() & 8'hEF;
        bus_write(sys_addr(daq_pkg::SYS_LEMO_MUX), lemo);
        bus_write(sys_addr(daq_pkg::SYS_CONTROL), ctrl);
        check_byte("control_outputs", lemo, o_lemo_mux);
        check_byte("control_outputs", {5'd0, ctrl[3:1]}, {5'd0, o_ntc_mux});
        check_bit("control_outputs", ~ctrl[0], o_mgt_ref_sel);
        check_bit("control_outputs", 1'b1, o_resetb_ext);
        bus_read(sys_addr(daq_pkg::SYS_LEMO_MUX), d);
        check_byte("control_outputs", lemo, d);
        bus_read(sys_addr(daq_pkg::SYS_CONTROL), d);
        check_byte("control_outputs", ctrl, d);
        r = rand_byte();
        @(negedge BUS_CLK);
        i_gpio_sense = r[3:0];
        bus_read(sys_addr(daq_pkg::SYS_SENSE), d);
        check_byte("control_outputs", {4'd0, r[3:0]}, d);
        bus_write(sys_addr(daq_pkg::SYS_CONTROL), ctrl | 8'h10);
        check_bit("control_outputs", 1'b0, o_resetb_ext);
        bus_write(sys_addr(daq_pkg::SYS_CONTROL), 8'h00);
        check_bit("control_outputs", 1'b1, o_resetb_ext);
        check_bit("control_outputs", 1'b1, o_mgt_ref_sel);
    endtask

    task automatic test_bus_pulse();
        logic [7:0] d;
        bus_write(pulse_addr(daq_pkg::PULSE_DELAY), 8'd3);
        bus_write(pulse_addr(daq_pkg::PULSE_WIDTH), 8'd4);
        bus_read(pulse_addr(daq_pkg::PULSE_DELAY), d);
        check_byte("bus_pulse", 8'd3, d);
        bus_read(pulse_addr(daq_pkg::PULSE_WIDTH), d);
        check_byte("bus_pulse", 8'd4, d);
        bus_write(pulse_addr(daq_pkg::PULSE_START), 8'd0);
        check_pulse_shape("bus_pulse", 3, 4);
        bus_read(pulse_addr(daq_pkg::PULSE_DONE), d);
        check_byte("bus_pulse", 8'd1, d);
        // Busy right after a start
        bus_write(pulse_addr(daq_pkg::PULSE_START), 8'd0);
        bus_read(pulse_addr(daq_pkg::PULSE_DONE), d);
        check_byte("bus_pulse", 8'd0, d);
        wait_pulse_idle("bus_pulse");
        bus_write(pulse_addr(daq_pkg::PULSE_WIDTH), 8'd0);
        bus_write(pulse_addr(daq_pkg::PULSE_START), 8'd0);
        check_pulse_shape("bus_pulse", 3, 0);
        wait_pulse_idle("bus_pulse");
        // Shortest pulse, no delay
        bus_write(pulse_addr(daq_pkg::PULSE_DELAY), 8'd0);
        bus_write(pulse_addr(daq_pkg::PULSE_WIDTH), 8'd1);
        bus_write(pulse_addr(daq_pkg::PULSE_START), 8'd0);
        check_pulse_shape("bus_pulse", 0, 1);
        wait_pulse_idle("bus_pulse");
    endtask

    task automatic test_ext_start();
        logic [7:0] d;
        bus_write(pulse_addr(daq_pkg::PULSE_DELAY), 8'd2);
        bus_write(pulse_addr(daq_pkg::PULSE_WIDTH), 8'd3);
        ext_start_pulse();
        check_pulse_shape("ext_start", 2, 0);
        bus_read(pulse_addr(daq_pkg::PULSE_DONE), d);
        check_byte("ext_start", 8'd1, d);
        bus_write(pulse_addr(daq_pkg::PULSE_EXT_EN), 8'd1);
        bus_read(pulse_addr(daq_pkg::PULSE_EXT_EN), d);
        check_byte("ext_start", 8'd1, d);
        ext_start_pulse();
        check_pulse_shape("ext_start", 2, 3);
        wait_pulse_idle("ext_start");
        bus_write(pulse_addr(daq_pkg::PULSE_EXT_EN), 8'd0);
    endtask

    // Equal fill levels, so the stream interleaves rx, tlu, tdc
    task automatic test_round_robin();
        logic [`DAQ_WORD_WIDTH-1:0] w;
        out_q.delete();
        exp_q.delete();
        for (int i = 0; i < 4; i++) begin
            w = tagged_word(4'h1);
            rx_q.push_back(w);
            exp_q.push_back(w);
            w = tagged_word(4'h2);
            tlu_q.push_back(w);
            exp_q.push_back(w);
            w = tagged_word(4'h3);
            tdc_q.push_back(w);
            exp_q.push_back(w);
        end
        wait_words("round_robin", 12);
        compare_stream("round_robin");
    endtask

    task automatic test_backpressure_hold();
        logic [`DAQ_WORD_WIDTH-1:0] rw[2];
        logic [`DAQ_WORD_WIDTH-1:0] tw[4];
        logic [`DAQ_WORD_WIDTH-1:0] cw[2];
        @(negedge BUS_CLK);
        i_arb_ready = 1'b0;
        @(negedge BUS_CLK);
        out_q.delete();
        exp_q.delete();
        for (int i = 0; i < 2; i++) begin
            rw[i] = tagged_word(4'h1);
            cw[i] = tagged_word(4'h3);
            rx_q.push_back(rw[i]);
            tdc_q.push_back(cw[i]);
        end
        for (int i = 0; i < 4; i++) begin
            tw[i] = tagged_word(4'h2);
            tlu_q.push_back(tw[i]);
        end
        i_tlu_fifo_preempt_req = 1'b1;
        repeat (10) @(negedge BUS_CLK);
        if (out_q.size() != 0) note_error("backpressure_hold: arbiter wrote while ready was low");
        if (rx_q.size() != 2 || tlu_q.size() != 4 || tdc_q.size() != 2) begin
            note_error("backpressure_hold: source FIFO popped while ready was low");
        end
        // Last grant was tdc, so rx first, then tlu locks until empty
        exp_q.push_back(rw[0]);
        for (int i = 0; i < 4; i++) exp_q.push_back(tw[i]);
        exp_q.push_back(cw[0]);
        exp_q.push_back(rw[1]);
        exp_q.push_back(cw[1]);
        i_arb_ready = 1'b1;
        wait_words("backpressure_hold", 8);
        compare_stream("backpressure_hold");
        i_tlu_fifo_preempt_req = 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        repeat (2) @(negedge BUS_CLK);
        BUS_RST = 1'b0;
        test_reg_readback();
        test_control_outputs();
        test_bus_pulse();
        test_ext_start();
        test_round_robin();
        test_backpressure_hold();
        repeat (4) @(negedge BUS_CLK);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("error: timeout after %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
